// File: Bender.yml
package:
  name: eeprom_ctrl

sources:
  - files:
      - common/eeprom_pkg.sv
      - common/i2c_pkg.sv
      - i2c_master/i2c_bit_engine.sv
      - hw/eeprom_sequencer.sv
      - hw/eeprom_ctrl_top.sv
  - target: test
    files:
      - verification/eeprom_slave_model.sv
      - verification/tb_eeprom_ctrl.sv

// File: common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // host side word address, 2 KB part
    localparam int ADDR_W  = 11;

    // upper address bits travel in the control byte
    localparam int BLOCK_W = 3;

    // low address bits sent as the word address byte
    localparam int WORD_W  = ADDR_W - BLOCK_W;

    localparam int DATA_W  = 8;

    // device type code in the top nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // transaction sequencer states
    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,      // start condition
        SEQ_CTRL,       // control byte, write bit
        SEQ_ADDR,       // word address byte
        SEQ_DATA,       // data byte of a write
        SEQ_RESTART,    // repeated start of a random read
        SEQ_CTRL_RD,    // control byte, read bit
        SEQ_READ,       // data byte from the slave
        SEQ_STOP,
        SEQ_FINISH      // one cycle, drives ack
    } seq_state_e;

endpackage

`default_nettype wire

// File: common/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // CLK cycles per SCL period, one per quarter
    localparam int QUARTERS  = 4;

    // eight data bits plus the acknowledge bit
    localparam int BYTE_BITS = 9;

    // commands from the sequencer to the bit engine
    typedef enum logic [1:0] {
        CMD_START,      // also used for the repeated start
        CMD_STOP,
        CMD_WRITE,      // byte out, ack from slave
        CMD_READ        // byte in, no ack from master
    } i2c_cmd_e;

    // bit engine states
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START,
        ENG_STOP,
        ENG_SHIFT,      // data bits of a byte
        ENG_ACK         // ninth bit
    } engine_state_e;

endpackage

`default_nettype wire

// File: compile.f
common/eeprom_pkg.sv
common/i2c_pkg.sv
i2c_master/i2c_bit_engine.sv
hw/eeprom_sequencer.sv
hw/eeprom_ctrl_top.sv
verification/eeprom_slave_model.sv
verification/tb_eeprom_ctrl.sv

// File: hw/eeprom_ctrl_top.sv
`default_nettype none

module eeprom_ctrl_top
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              wr,
    input  wire logic              rd,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] wdata,
    output logic      [DATA_W-1:0] rdata,
    output logic                   ack,
    output logic                   nack,
    output logic                   scl,
    inout  wire                    sda
);

    logic              cmd_valid;
    i2c_cmd_e          cmd;
    logic [DATA_W-1:0] tx_byte;
    logic [DATA_W-1:0] rx_byte;
    logic              done;
    logic              ack_seen;
    logic              sda_pull;
    logic              sda_in;

    // open drain, the pullup sits on the board
    assign sda    = sda_pull ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_sequencer i_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .ack       (ack),
        .nack      (nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .done      (done),
        .ack_seen  (ack_seen),
        .rx_byte   (rx_byte)
    );

    i2c_bit_engine i_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .done      (done),
        .ack_seen  (ack_seen),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

// File: hw/eeprom_sequencer.sv
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              wr,
    input  wire logic              rd,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [DATA_W-1:0] wdata,
    output logic      [DATA_W-1:0] rdata,
    output logic                   ack,
    output logic                   nack,
    output logic                   cmd_valid,
    output i2c_cmd_e               cmd,
    output logic      [DATA_W-1:0] tx_byte,
    input  wire logic              done,
    input  wire logic              ack_seen,
    input  wire logic [DATA_W-1:0] rx_byte
);

    seq_state_e        state;
    seq_state_e        state_n;
    logic              is_read;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              start_req;
    logic              byte_nacked;

    function automatic logic [DATA_W-1:0] ctrl_byte(
        input logic [ADDR_W-1:0] a,
        input logic              rnw
    );
        ctrl_byte = {DEV_CODE, a[ADDR_W-1 -: BLOCK_W], rnw};
    endfunction

    assign start_req = wr | rd;     // only looked at in idle

    // slave left SDA high in the ninth bit of one of our bytes
    assign byte_nacked = done && !ack_seen &&
                         (state inside {SEQ_CTRL, SEQ_ADDR, SEQ_DATA, SEQ_CTRL_RD});

    assign ack = (state == SEQ_FINISH);

    always_comb
    begin
        state_n = state;
        case (state)
            SEQ_IDLE:
                if (start_req)
                    state_n = SEQ_START;
            SEQ_START:
                if (done)
                    state_n = SEQ_CTRL;
            SEQ_CTRL:
                if (done)
                    state_n = byte_nacked ? SEQ_STOP : SEQ_ADDR;
            SEQ_ADDR:
                if (done)
                begin
                    if (byte_nacked)
                        state_n = SEQ_STOP;
                    else
                        state_n = is_read ? SEQ_RESTART : SEQ_DATA;
                end
            SEQ_DATA:
                if (done)
                    state_n = SEQ_STOP;
            SEQ_RESTART:
                if (done)
                    state_n = SEQ_CTRL_RD;
            SEQ_CTRL_RD:
                if (done)
                    state_n = byte_nacked ? SEQ_STOP : SEQ_READ;
            SEQ_READ:
                if (done)
                    state_n = SEQ_STOP;
            SEQ_STOP:
                if (done)
                    state_n = SEQ_FINISH;
            default:
                state_n = SEQ_IDLE;
        endcase
    end

    // command and byte follow the state, cmd_valid marks its first cycle
    always_comb
    begin
        cmd     = CMD_WRITE;
        tx_byte = wdata_q;
        case (state)
            SEQ_START, SEQ_RESTART:         cmd = CMD_START;
            SEQ_READ:                       cmd = CMD_READ;
            SEQ_IDLE, SEQ_STOP, SEQ_FINISH: cmd = CMD_STOP;
            SEQ_CTRL:    tx_byte = ctrl_byte(addr_q, 1'b0);
            SEQ_CTRL_RD: tx_byte = ctrl_byte(addr_q, 1'b1);
            SEQ_ADDR:    tx_byte = addr_q[WORD_W-1:0];
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= SEQ_IDLE;
            cmd_valid <= 1'b0;
            is_read   <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            state     <= state_n;
            // one command per bus state entered
            cmd_valid <= (state_n != state) && !(state_n inside {SEQ_IDLE, SEQ_FINISH});
            if (state == SEQ_IDLE && start_req)
            begin
                is_read <= !wr;             // write wins
                nack    <= 1'b0;
            end
            else if (byte_nacked)
                nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == SEQ_IDLE && start_req)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (state == SEQ_READ && done)
            rdata <= rx_byte;               // held until the next read
    end

    ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack);

    // no new command until the engine reports the last one
    one_cmd_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |=> !cmd_valid until_with done);

endmodule

`default_nettype wire

// File: i2c_master/i2c_bit_engine.sv
`default_nettype none

module i2c_bit_engine
    import eeprom_pkg::*, i2c_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              cmd_valid,
    input  wire i2c_cmd_e          cmd,
    input  wire logic [DATA_W-1:0] tx_byte,
    output logic                   done,
    output logic                   ack_seen,
    output logic      [DATA_W-1:0] rx_byte,
    output logic                   scl,
    output logic                   sda_pull,
    input  wire logic              sda_in
);

    engine_state_e                state;
    engine_state_e                state_n;
    logic [$clog2(QUARTERS)-1:0]  q;
    logic [$clog2(QUARTERS)-1:0]  q_n;
    logic [$clog2(BYTE_BITS)-1:0] bit_cnt;
    logic [$clog2(BYTE_BITS)-1:0] bit_n;
    logic [DATA_W-1:0]            sreg;
    logic                         rd_mode;
    logic                         rd_n;
    logic                         scl_n;
    logic                         pull_n;
    logic                         tx_bit;
    logic                         last_q;
    logic                         sample_q;

    assign last_q   = (q == QUARTERS - 1);
    assign sample_q = (q == QUARTERS / 2);     // middle of SCL high

    // first bit comes straight from the command, later ones from the shifter
    assign tx_bit = (state == ENG_IDLE) ? tx_byte[DATA_W-1] : sreg[DATA_W-1];

    // start, stop and ack each end a command on their last quarter
    assign done = last_q && (state != ENG_IDLE) && (state != ENG_SHIFT);

    assign rx_byte = sreg;

    always_comb
    begin
        state_n = state;
        q_n     = q + 1'b1;
        bit_n   = bit_cnt;
        rd_n    = rd_mode;
        case (state)
            ENG_IDLE:
            begin
                q_n   = '0;
                bit_n = '0;
                if (cmd_valid)
                begin
                    rd_n = (cmd == CMD_READ);
                    case (cmd)
                        CMD_START: state_n = ENG_START;
                        CMD_STOP:  state_n = ENG_STOP;
                        default:   state_n = ENG_SHIFT;
                    endcase
                end
            end
            ENG_SHIFT:
                if (last_q)
                begin
                    if (bit_cnt == BYTE_BITS - 2)
                        state_n = ENG_ACK;
                    else
                        bit_n = bit_cnt + 1'b1;
                end
            default:
                if (last_q)
                    state_n = ENG_IDLE;
        endcase
    end

    // bus levels for the quarter being entered, idle holds the last ones
    always_comb
    begin
        scl_n  = scl;
        pull_n = sda_pull;
        case (state_n)
            ENG_START:
                case (q_n)
                    2'd0:    pull_n = 1'b0;     // release, SCL as it was
                    2'd1:    scl_n  = 1'b1;
                    2'd2:    pull_n = 1'b1;     // SDA falls with SCL high
                    default: scl_n  = 1'b0;
                endcase
            ENG_STOP:
                case (q_n)
                    2'd0:
                    begin
                        pull_n = 1'b1;
                        scl_n  = 1'b0;
                    end
                    2'd1:    scl_n  = 1'b1;
                    2'd2:    pull_n = 1'b0;     // SDA rises with SCL high
                    default: ;
                endcase
            ENG_SHIFT, ENG_ACK:
                case (q_n)
                    2'd0:
                    begin
                        scl_n  = 1'b0;
                        // reads and the ninth bit leave SDA to the slave
                        pull_n = (state_n == ENG_SHIFT) && !rd_n && !tx_bit;
                    end
                    2'd1:    scl_n = 1'b1;
                    2'd3:    scl_n = 1'b0;
                    default: ;
                endcase
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ENG_IDLE;
            q        <= '0;
            bit_cnt  <= '0;
            rd_mode  <= 1'b0;
            scl      <= 1'b1;               // bus idle
            sda_pull <= 1'b0;
            ack_seen <= 1'b0;
        end
        else
        begin
            state    <= state_n;
            q        <= q_n;
            bit_cnt  <= bit_n;
            rd_mode  <= rd_n;
            scl      <= scl_n;
            sda_pull <= pull_n;
            if (state == ENG_ACK && sample_q)
                ack_seen <= !sda_in;        // slave holds SDA low
        end
    end

    // shifts out MSB first and takes the bus level in at the same time
    always_ff @(posedge CLK)
    begin
        if (state == ENG_IDLE && cmd_valid)
            sreg <= tx_byte;
        else if (state == ENG_SHIFT && sample_q)
            sreg <= {sreg[DATA_W-2:0], sda_in};
    end

    // data may only move while SCL is low
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (state inside {ENG_SHIFT, ENG_ACK}) && scl |-> $stable(sda_pull));

endmodule

`default_nettype wire

// File: verification/eeprom_slave_model.sv
`default_nettype none

module eeprom_slave_model
    import eeprom_pkg::*;
(
    input  wire logic scl,
    inout  wire       sda,
    input  wire logic en
);
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CTRL,
        S_WORD,
        S_WDATA,
        S_RDATA
    } slave_phase_e;

    logic [DATA_W-1:0]  mem [0:(1 << ADDR_W)-1];
    slave_phase_e       phase;
    logic [3:0]         cnt;        // rising SCL edges in this byte
    logic [DATA_W-1:0]  shift;
    logic [DATA_W-1:0]  tx;
    logic [BLOCK_W-1:0] block;
    logic [ADDR_W-1:0]  ptr;
    logic               rnw;
    logic               matched;
    logic               drive_low;
    logic               scl_d;
    logic               sda_d;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = 8'hFF;
        phase     = S_IDLE;
        cnt       = '0;
        drive_low = 1'b0;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl === 1'b1 && scl_d === 1'b1 && sda !== sda_d)
        begin
            // start or stop, both restart the byte framing
            drive_low = 1'b0;
            cnt       = '0;
            phase     = (sda === 1'b0) ? S_CTRL : S_IDLE;
        end
        else if (scl === 1'b1 && scl_d !== 1'b1 && phase != S_IDLE)
        begin
            shift = {shift[DATA_W-2:0], sda !== 1'b0};
            cnt   = cnt + 1'b1;
        end
        else if (scl !== 1'b1 && scl_d === 1'b1 && phase != S_IDLE && cnt != 0)
        begin
            if (cnt == 8)
            begin
                drive_low = 1'b0;   // read data: master owns the ninth bit
                case (phase)
                    S_CTRL:
                    begin
                        matched   = en && (shift[DATA_W-1 -: 4] == DEV_CODE);
                        block     = shift[BLOCK_W:1];
                        rnw       = shift[0];
                        drive_low = matched;
                    end
                    S_WORD:
                    begin
                        ptr       = {block, shift};
                        drive_low = 1'b1;
                    end
                    S_WDATA:
                    begin
                        mem[ptr]  = shift;
                        drive_low = 1'b1;
                    end
                    default: ;
                endcase
            end
            else if (cnt == 9)
            begin
                cnt       = '0;
                drive_low = 1'b0;
                case (phase)
                    S_CTRL:  phase = !matched ? S_IDLE : (rnw ? S_RDATA : S_WORD);
                    S_WORD:  phase = S_WDATA;
                    S_RDATA: phase = S_IDLE;    // single byte, master nacks
                    default: ;
                endcase
                if (phase == S_RDATA)
                begin
                    tx        = mem[ptr];
                    drive_low = !tx[DATA_W-1];
                end
            end
            else if (phase == S_RDATA)
                drive_low = !tx[DATA_W-1-cnt];
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

`default_nettype wire

// File: verification/tb_eeprom_ctrl.sv
`default_nettype none

module tb_eeprom_ctrl
    import eeprom_pkg::*, i2c_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_TIMEOUT = 16 * BYTE_BITS * QUARTERS;   // cycles

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              ack;
    logic              nack;
    logic              scl;
    wire               sda;
    logic              slave_en;
    logic [DATA_W-1:0] shadow [0:(1 << ADDR_W)-1];
    logic [31:0]       lfsr;
    int                starts;
    int                stops;
    int                acks;
    int                accepted;
    logic              in_txn;
    logic              scl_q;
    logic              sda_q;

    pullup (sda);

    eeprom_ctrl_top i_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ack   (ack),
        .nack  (nack),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_slave_model i_slave (
        .scl (scl),
        .sda (sda),
        .en  (slave_en)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Fail %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // galois form, shifts right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        repeat (n)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // start and stop conditions, ack pulses
    always @(negedge CLK)
    begin
        if (!RESET && scl_q === 1'b1 && scl === 1'b1 && sda !== sda_q)
        begin
            if (sda === 1'b0)
                in_txn = 1'b1;
            else
            begin
                assert (in_txn)
                else
                begin
                    $display("stop condition without a start at %0t ns", $time);
                    abort_run();
                end
                in_txn = 1'b0;
            end
            if (sda === 1'b0)
                starts++;
            else
                stops++;
        end
        scl_q = scl;
        sda_q = sda;
        if (!RESET && ack === 1'b1)
            acks++;
    end

    bus_rests_high: assert property (@(posedge CLK) disable iff (RESET)
        !in_txn |-> (scl === 1'b1 && sda === 1'b1))
    else
    begin
        $display("Fail %0t ns scl/sda got %b/%b expected 1/1", $time,
                 $sampled(scl), $sampled(sda));
        abort_run();
    end

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge CLK);
            expect_equal("ack", ack, 1'b0);
            expect_equal("scl", scl, 1'b1);
            expect_equal("sda", sda, 1'b1);
        end
    endtask

    task automatic transfer(input logic write, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic poke,
                            input logic exp_nack);
        int start0;
        int stop0;
        int n;
        start0 = starts;
        stop0  = stops;
        @(posedge CLK);
        wr    <= write;
        rd    <= !write;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        accepted++;
        if (poke)
        begin
            repeat (6) @(posedge CLK);
            wr    <= 1'b1;      // sequencer busy, dropped
            rd    <= 1'b1;
            addr  <= ~a;
            wdata <= ~d;
            @(posedge CLK);
            wr <= 1'b0;
            rd <= 1'b0;
        end
        n = 0;
        do
        begin
            @(negedge CLK);
            n++;
            if (n > ACK_TIMEOUT)
            begin
                $display("no ack within %0d cycles at %0t ns", ACK_TIMEOUT, $time);
                abort_run();
            end
        end
        while (ack !== 1'b1);
        expect_equal("nack", nack, exp_nack);
        if (!write && !exp_nack)
            expect_equal("rdata", rdata, shadow[a]);
        if (write && !exp_nack)
            shadow[a] = d;
        // repeated start only on an acknowledged read
        expect_equal("starts", starts - start0, (write || exp_nack) ? 1 : 2);
        expect_equal("stops", stops - stop0, 1);
        idle_cycles(2);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] d;
        logic        op;
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = '0;
        slave_en = 1'b1;
        lfsr     = 32'h0ba8b0c6;
        starts   = 0;
        stops    = 0;
        acks     = 0;
        accepted = 0;
        in_txn   = 1'b0;
        for (int i = 0; i < (1 << ADDR_W); i++)
            shadow[i] = 8'hFF;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        idle_cycles(3);

        transfer(1'b1, 11'h2a5, 8'h3c, 1'b0, 1'b0);
        transfer(1'b0, 11'h2a5, 8'h00, 1'b0, 1'b0);
        transfer(1'b0, 11'h7ff, 8'h00, 1'b0, 1'b0);

        // each block in turn, few words so reads hit earlier writes
        for (int k = 0; k < 48; k++)
        begin
            r  = random_bits(2);
            op = random_bits(1);
            d  = random_bits(DATA_W);
            transfer(op, {k[BLOCK_W-1:0], r[1:0], 6'h2d}, d[DATA_W-1:0],
                     (k % 5) == 2, 1'b0);
        end

        slave_en = 1'b0;
        transfer(1'b1, 11'h2a5, 8'hc3, 1'b1, 1'b1);
        slave_en = 1'b1;
        transfer(1'b0, 11'h2a5, 8'h00, 1'b0, 1'b0);

        expect_equal("ack pulses", acks, accepted);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
